//--- ahbic_in_stage.f
common/ahbic_pkg.sv
ahbic_in/ahbic_hold_ctrl.sv
ahbic_in/ahbic_hold_reg.sv
ahbic_in/ahbic_burst_fix.sv
ahbic_in/ahbic_in_stage.sv
dv/ahbic_in_properties.sv
dv/tb_ahbic_in_stage.sv

//--- Bender.yml
package:
  name: ahbic_in_stage

sources:
  # Shared encodings
  - common/ahbic_pkg.sv
  # Input stage RTL
  - ahbic_in/ahbic_hold_ctrl.sv
  - ahbic_in/ahbic_hold_reg.sv
  - ahbic_in/ahbic_burst_fix.sv
  - ahbic_in/ahbic_in_stage.sv
  # Testbench and bound assertions
  - target: test
    files:
      - dv/ahbic_in_properties.sv
      - dv/tb_ahbic_in_stage.sv

//--- dv/tb_ahbic_in_stage.sv
// Testbench for the input stage: clock, reset, random AHB master, reference model, checks, watchdog

`timescale 1ns/10ps
`default_nettype none

module tb_ahbic_in_stage
  import ahbic_pkg::*;
();

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned CLK_PERIOD = 4;     // ns
  localparam int unsigned RST_CYCLES = 4;
  localparam int unsigned NUM_CYCLES = 4000;
  localparam int unsigned WD_LIMIT   = (RST_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

  // DUT ports, names match the top level
  logic                HCLK;
  logic                HRESETn;
  logic                HSELS;
  logic [ADDR_W-1:0]   HADDRS;
  htrans_t             HTRANSS;
  logic                HWRITES;
  hsize_t              HSIZES;
  hburst_t             HBURSTS;
  logic [HPROT_W-1:0]  HPROTS;
  logic                HREADYS;
  logic                active_ip;
  logic                readyout_ip;
  hresp_t              resp_ip;
  logic                HREADYOUTS;
  hresp_t              HRESPS;
  logic                sel_ip;
  logic [ADDR_W-1:0]   addr_ip;
  htrans_t             trans_ip;
  logic                write_ip;
  hsize_t              size_ip;
  hburst_t             burst_ip;
  logic [HPROT_W-1:0]  prot_ip;
  logic                held_tran;

  // Reference model state
  logic                m_pend;            // Pending hold
  logic                m_dv;              // Data phase valid
  logic                m_ovr;             // Burst override
  logic                m_bound;           // Wrap boundary
  logic [ADDR_W-1:0]   h_addr;            // Holding copy
  htrans_t             h_trans;
  logic                h_write;
  hsize_t              h_size;
  hburst_t             h_burst;
  logic [HPROT_W-1:0]  h_prot;

  integer              seed = 32'h7802_f721;
  int unsigned         beats_left;        // Master beats still to send

  ahbic_in_stage #(
    .ADDR_W (ADDR_W)
  ) i_dut (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  task automatic check_value(input string name, input logic [ADDR_W-1:0] actual,
                             input logic [ADDR_W-1:0] expected);
    begin
      if (actual !== expected)
      begin
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
        $display(">>> FAIL");
        $fatal(1, "Output mismatch on %s", name);
      end
    end
  endtask

  function automatic logic is_addr_valid(input htrans_t t);
    return (t == TRN_NONSEQ) || (t == TRN_SEQ);
  endfunction

  function automatic int unsigned wrap_beats(input hburst_t b);
    case (b)
      BUR_WRAP4:  return 4;
      BUR_WRAP8:  return 8;
      BUR_WRAP16: return 16;
      default:    return 0;   // Not a wrapping burst
    endcase
  endfunction

  // Beat sits in the last slot of its wrap block
  function automatic logic is_wrap_last(input logic [ADDR_W-1:0] addr, input hsize_t size,
                                        input hburst_t burst);
    int unsigned beats;
    int unsigned idx;
    begin
      beats = wrap_beats(burst);
      idx   = addr >> size;
      return (beats != 0) && ((idx % beats) == beats - 1);
    end
  endfunction

  // Next beat address; all-ones mask for incrementing bursts
  function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] addr,
                                                  input hsize_t size, input hburst_t burst);
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] blk;
    begin
      step = 32'd1 << size;
      blk  = wrap_beats(burst) * step - 1;
      return (addr & ~blk) | ((addr + step) & blk);
    end
  endfunction

  function automatic logic expected_ready();
    if (!m_dv)
      return 1'b1;
    return m_pend ? 1'b0 : readyout_ip;   // Stall while held beat waits
  endfunction

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  // Random AHB master, one address phase per completed beat
  task automatic step_master();
    int unsigned r;
    logic [2:0]  rnd3;
    begin
      r = $unsigned($random(seed)) % 8;
      if (beats_left > 0 && r >= 3)
      begin
        HADDRS  = next_addr(HADDRS, HSIZES, HBURSTS);
        HTRANSS = TRN_SEQ;
        beats_left--;
      end
      else if (beats_left > 0 && r == 2)
        HTRANSS = TRN_BUSY;                  // Address kept, beat not used up
      else if (r == 0 || (beats_left == 0 && r < 3))
      begin
        HTRANSS    = TRN_IDLE;
        HSELS      = ($unsigned($random(seed)) % 4) != 0;
        beats_left = 0;
      end
      else
      begin
        HSELS   = ($unsigned($random(seed)) % 8) != 0;
        HWRITES = $random(seed);
        HPROTS  = $random(seed);
        rnd3    = $random(seed);
        HBURSTS = hburst_t'(rnd3);
        rnd3    = $unsigned($random(seed)) % 4;   // 8 to 64 bit beats
        HSIZES  = hsize_t'(rnd3);
        HADDRS  = $random(seed);
        HADDRS  = HADDRS & ~((32'd1 << HSIZES) - 1);
        HTRANSS = TRN_NONSEQ;
        case (HBURSTS)
          BUR_SINGLE:             beats_left = 0;
          BUR_INCR:               beats_left = $unsigned($random(seed)) % 8;
          BUR_WRAP4, BUR_INCR4:   beats_left = 3;
          BUR_WRAP8, BUR_INCR8:   beats_left = 7;
          default:                beats_left = 15;
        endcase
      end
    end
  endtask

  task automatic drive_cycle(input logic idle_only);
    logic exp_rdy;
    begin
      active_ip   = ($unsigned($random(seed)) % 8) < 3;   // Mostly busy, holds often
      readyout_ip = ($unsigned($random(seed)) % 4) != 0;
      resp_ip     = (($unsigned($random(seed)) % 8) == 0) ? RSP_ERROR : RSP_OKAY;
      exp_rdy     = expected_ready();
      if (idle_only)
      begin
        HSELS      = 1'b0;
        HTRANSS    = TRN_IDLE;
        beats_left = 0;
      end
      else if (HREADYS)
        step_master();                       // Previous beat taken
      HREADYS = exp_rdy;                     // Single slave, HREADY loops back
    end
  endtask

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------

  task automatic check_outputs();
    logic    load;
    htrans_t base_trans;
    htrans_t src_trans;
    hburst_t base_burst;
    htrans_t exp_trans;
    begin
      load = HSELS && is_addr_valid(HTRANSS) && HREADYS;
      check_value("HREADYOUTS", HREADYOUTS, expected_ready());
      check_value("HRESPS", HRESPS, (m_dv && !m_pend) ? resp_ip : RSP_OKAY);
      check_value("held_tran", held_tran, load || m_pend);
      if (m_pend)
      begin
        check_value("sel_ip", sel_ip, 1'b1);
        check_value("addr_ip", addr_ip, h_addr);
        check_value("write_ip", write_ip, h_write);
        check_value("size_ip", size_ip, h_size);
        check_value("prot_ip", prot_ip, h_prot);
        base_trans = TRN_NONSEQ;             // Held beat restarts
        base_burst = h_burst;
        src_trans  = h_trans;
      end
      else
      begin
        check_value("sel_ip", sel_ip, HSELS);
        check_value("addr_ip", addr_ip, HADDRS);
        check_value("write_ip", write_ip, HWRITES);
        check_value("size_ip", size_ip, HSIZES);
        check_value("prot_ip", prot_ip, HPROTS);
        base_trans = HTRANSS;
        base_burst = HBURSTS;
        src_trans  = HTRANSS;
      end
      exp_trans = base_trans;
      if (m_ovr && m_bound && base_trans == TRN_SEQ)
        exp_trans = TRN_NONSEQ;
      else if (m_ovr && m_bound && base_trans == TRN_BUSY)
        exp_trans = TRN_IDLE;
      check_value("trans_ip", trans_ip, exp_trans);
      check_value("burst_ip", burst_ip,
                  (m_ovr && src_trans != TRN_NONSEQ) ? BUR_INCR : base_burst);
    end
  endtask

  // State update for the coming edge
  task automatic update_model();
    logic load;
    logic hold;
    begin
      load = HSELS && is_addr_valid(HTRANSS) && HREADYS;
      hold = load && !active_ip;
      if (HREADYS)
        m_dv = HSELS && is_addr_valid(HTRANSS);
      if (hold)
        m_pend = 1'b1;
      else if (active_ip && readyout_ip)
        m_pend = 1'b0;
      if (load)
      begin
        h_addr  = HADDRS;
        h_trans = HTRANSS;
        h_write = HWRITES;
        h_size  = HSIZES;
        h_burst = HBURSTS;
        h_prot  = HPROTS;
      end
      if (HREADYS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE))
        m_ovr = 1'b0;
      else if (HREADYS && HTRANSS == TRN_SEQ && hold)
        m_ovr = 1'b1;
      if (HREADYS && is_addr_valid(HTRANSS))
        m_bound = is_wrap_last(HADDRS, HSIZES, HBURSTS);
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------

  initial
  begin
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = TRN_IDLE;
    HWRITES     = 1'b0;
    HSIZES      = SZ_8;
    HBURSTS     = BUR_SINGLE;
    HPROTS      = '0;
    HREADYS     = 1'b1;
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;
    m_pend      = 1'b0;
    m_dv        = 1'b0;
    m_ovr       = 1'b0;
    m_bound     = 1'b0;
    h_trans     = TRN_IDLE;
    beats_left  = 0;
    repeat (RST_CYCLES) @(posedge HCLK);
    #1 HRESETn = 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
    begin
      @(posedge HCLK);
      #1;
      drive_cycle(cyc < 3);                  // Idle bus right after reset
      #1;
      check_outputs();
      check_value("assertion failures", i_dut.i_properties.fail_count, 0);
      update_model();
    end
    $display(">>> PASS");
    $finish;
  end

  initial
  begin
    #(WD_LIMIT);
    $display("Timeout: simulation still running after %0d ns", WD_LIMIT);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule : tb_ahbic_in_stage

`default_nettype wire

//--- dv/ahbic_in_properties.sv
// Concurrent assertions on the input stage, bound to the top level

`timescale 1ns/10ps
`default_nettype none

module ahbic_in_properties
  import ahbic_pkg::*;
(
  input wire          HCLK,
  input wire          HRESETn,
  input wire          HSELS,
  input wire htrans_t HTRANSS,
  input wire          HREADYS,
  input wire          HREADYOUTS,
  input wire          pend,        // Held transfer waiting
  input wire          held_tran,
  input wire          sel_ip,
  input wire htrans_t trans_ip
);

  logic        dphase;          // Data phase of a selected NONSEQ or SEQ
  int unsigned fail_count = 0;  // Failed assertions so far

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      dphase <= 1'b0;
    else if (HREADYS)
      dphase <= HSELS & HTRANSS[1];
  end

  // --------------------------------------------------------------------
  // Properties
  // --------------------------------------------------------------------

  a_ready_no_dphase : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !dphase |-> HREADYOUTS)
    else
    begin
      $error("HREADYOUTS low with no data phase active");
      fail_count++;
    end

  a_held_while_pend : assert property (@(posedge HCLK) disable iff (!HRESETn)
    pend |-> held_tran)
    else
    begin
      $error("held_tran low while a held transfer is pending");
      fail_count++;
    end

  // Held beat always presented as a live transfer
  a_pend_select : assert property (@(posedge HCLK) disable iff (!HRESETn)
    pend |-> (sel_ip && trans_ip != TRN_IDLE))
    else
    begin
      $error("Held transfer not selected or shown as IDLE");
      fail_count++;
    end

endmodule : ahbic_in_properties

bind ahbic_in_stage ahbic_in_properties i_properties (
  .HCLK       (HCLK),
  .HRESETn    (HRESETn),
  .HSELS      (HSELS),
  .HTRANSS    (HTRANSS),
  .HREADYS    (HREADYS),
  .HREADYOUTS (HREADYOUTS),
  .pend       (pend),
  .held_tran  (held_tran),
  .sel_ip     (sel_ip),
  .trans_ip   (trans_ip)
);

`default_nettype wire

//--- ahbic_in/ahbic_in_stage.sv
// Input stage top level: hold control, holding register and burst fix wired together

`timescale 1ns/10ps
`default_nettype none

module ahbic_in_stage
  import ahbic_pkg::*;
#(
  parameter int unsigned ADDR_W = 32  // Address width, 7 or more
) (
  input  wire                 HCLK,
  input  wire                 HRESETn,
  // Master port, address phase
  input  wire                 HSELS,
  input  wire  [ADDR_W-1:0]   HADDRS,
  input  wire  htrans_t       HTRANSS,
  input  wire                 HWRITES,
  input  wire  hsize_t        HSIZES,
  input  wire  hburst_t       HBURSTS,
  input  wire  [HPROT_W-1:0]  HPROTS,
  input  wire                 HREADYS,
  // From the output stage
  input  wire                 active_ip,    // Output stage driving this port
  input  wire                 readyout_ip,
  input  wire  hresp_t        resp_ip,
  // Master port, response
  output logic                HREADYOUTS,
  output hresp_t              HRESPS,
  // To the output stage
  output logic                sel_ip,
  output logic [ADDR_W-1:0]   addr_ip,
  output htrans_t             trans_ip,
  output logic                write_ip,
  output hsize_t              size_ip,
  output hburst_t             burst_ip,
  output logic [HPROT_W-1:0]  prot_ip,
  output logic                held_tran     // Request to the arbiter
);

  // --------------------------------------------------------------------
  // Internal connections
  // --------------------------------------------------------------------

  logic    load_reg;    // Valid transfer accepted
  logic    hold_start;  // Accepted but output stage busy
  logic    pend;        // Held transfer waiting
  htrans_t trans_mux;   // Selected HTRANS, before rewrite
  hburst_t burst_mux;   // Selected HBURST, before rewrite
  htrans_t trans_src;   // Original HTRANS of selected source

  // Acceptance, pending state and response path
  ahbic_hold_ctrl i_hold_ctrl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSELS       (HSELS),
    .HTRANSS     (HTRANSS),
    .HREADYS     (HREADYS),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .load_reg    (load_reg),
    .hold_start  (hold_start),
    .pend        (pend),
    .held_tran   (held_tran),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS)
  );

  // Holding register and held/direct select
  ahbic_hold_reg #(
    .ADDR_W (ADDR_W)
  ) i_hold_reg (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .load_reg  (load_reg),
    .pend      (pend),
    .HSELS     (HSELS),
    .HADDRS    (HADDRS),
    .HTRANSS   (HTRANSS),
    .HWRITES   (HWRITES),
    .HSIZES    (HSIZES),
    .HBURSTS   (HBURSTS),
    .HPROTS    (HPROTS),
    .sel_ip    (sel_ip),
    .addr_ip   (addr_ip),
    .write_ip  (write_ip),
    .size_ip   (size_ip),
    .prot_ip   (prot_ip),
    .trans_mux (trans_mux),
    .burst_mux (burst_mux),
    .trans_src (trans_src)
  );

  // Early burst termination
  ahbic_burst_fix #(
    .ADDR_W (ADDR_W)
  ) i_burst_fix (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HREADYS    (HREADYS),
    .HTRANSS    (HTRANSS),
    .HADDRS     (HADDRS),
    .HSIZES     (HSIZES),
    .HBURSTS    (HBURSTS),
    .hold_start (hold_start),
    .trans_mux  (trans_mux),
    .burst_mux  (burst_mux),
    .trans_src  (trans_src),
    .trans_ip   (trans_ip),
    .burst_ip   (burst_ip)
  );

endmodule : ahbic_in_stage

`default_nettype wire

//--- ahbic_in/ahbic_burst_fix.sv
// Early burst termination: burst override, wrap boundary flag and HTRANS/HBURST rewrite

`timescale 1ns/10ps
`default_nettype none

module ahbic_burst_fix
  import ahbic_pkg::*;
#(
  parameter int unsigned ADDR_W = 32
) (
  input  wire                HCLK,
  input  wire                HRESETn,
  input  wire                HREADYS,
  input  wire  htrans_t      HTRANSS,
  input  wire  [ADDR_W-1:0]  HADDRS,
  input  wire  hsize_t       HSIZES,
  input  wire  hburst_t      HBURSTS,
  input  wire                hold_start,  // Beat goes into holding register
  input  wire  htrans_t      trans_mux,
  input  wire  hburst_t      burst_mux,
  input  wire  htrans_t      trans_src,
  output htrans_t            trans_ip,
  output hburst_t            burst_ip
);

  logic                   override_nxt;
  logic                   override;      // Remainder of burst sent as INCR
  logic [1:0]             size_shift;    // Bytes per beat, log2
  logic [ADDR_W-1:0]      beat_addr;     // Address in beat units
  logic [WRAP_OFS_W-1:0]  beat_ofs;
  logic [WRAP_OFS_W-1:0]  check_ofs;     // Offset padded with ones
  logic                   bound_nxt;
  logic                   bound;         // Last beat was end of wrap block

  // --------------------------------------------------------------------
  // Burst override
  // --------------------------------------------------------------------

  // A held SEQ beat breaks the fixed-length burst
  always_comb
  begin
    if (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE)
    begin
      override_nxt = 1'b0;       // New burst or bus released
    end
    else if (HTRANSS == TRN_SEQ && hold_start)
    begin
      override_nxt = 1'b1;
    end
    else
    begin
      override_nxt = override;   // BUSY or unheld SEQ
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      override <= 1'b0;
    end
    else if (HREADYS)
    begin
      override <= override_nxt;
    end
  end

  // --------------------------------------------------------------------
  // Wrap boundary detection
  // --------------------------------------------------------------------

  // Sizes above 64 bits treated as bytes
  assign size_shift = HSIZES[2] ? 2'd0 : HSIZES[1:0];
  assign beat_addr  = HADDRS >> size_shift;
  assign beat_ofs   = beat_addr[WRAP_OFS_W-1:0];

  // Bits above the wrap length forced high
  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4:  check_ofs = {2'b11, beat_ofs[1:0]};
      BUR_WRAP8:  check_ofs = {1'b1, beat_ofs[2:0]};
      BUR_WRAP16: check_ofs = beat_ofs;
      default:    check_ofs = '0;   // Incrementing bursts never wrap
    endcase
  end

  assign bound_nxt = &check_ofs;

  // Sampled on accepted NONSEQ or SEQ only
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      bound <= 1'b0;
    end
    else if (HTRANSS[1] && HREADYS)
    begin
      bound <= bound_nxt;
    end
  end

  // --------------------------------------------------------------------
  // Rewrite
  // --------------------------------------------------------------------

  // SEQ to NONSEQ and BUSY to IDLE after a wrap point
  assign trans_ip = (override && bound) ? htrans_t'({trans_mux[1], 1'b0}) : trans_mux;

  // NONSEQ keeps its own burst type
  assign burst_ip = (override && trans_src != TRN_NONSEQ) ? BUR_INCR : burst_mux;

endmodule : ahbic_burst_fix

`default_nettype wire

//--- ahbic_in/ahbic_hold_reg.sv
// Holding register for address and control, with held/direct output select

`timescale 1ns/10ps
`default_nettype none

module ahbic_hold_reg
  import ahbic_pkg::*;
#(
  parameter int unsigned ADDR_W = 32
) (
  input  wire                 HCLK,
  input  wire                 HRESETn,
  input  wire                 load_reg,   // Capture current address phase
  input  wire                 pend,       // Present held copy
  input  wire                 HSELS,
  input  wire  [ADDR_W-1:0]   HADDRS,
  input  wire  htrans_t       HTRANSS,
  input  wire                 HWRITES,
  input  wire  hsize_t        HSIZES,
  input  wire  hburst_t       HBURSTS,
  input  wire  [HPROT_W-1:0]  HPROTS,
  output logic                sel_ip,
  output logic [ADDR_W-1:0]   addr_ip,
  output logic                write_ip,
  output hsize_t              size_ip,
  output logic [HPROT_W-1:0]  prot_ip,
  output htrans_t             trans_mux,
  output hburst_t             burst_mux,
  output htrans_t             trans_src   // Unmodified type of chosen source
);

  // --------------------------------------------------------------------
  // Holding register
  // --------------------------------------------------------------------

  htrans_t             reg_trans;
  logic [ADDR_W-1:0]   reg_addr;
  logic                reg_write;
  hsize_t              reg_size;
  hburst_t             reg_burst;
  logic [HPROT_W-1:0]  reg_prot;

  // Held type steers the burst fix, so it starts from IDLE
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      reg_trans <= TRN_IDLE;
    end
    else if (load_reg)
    begin
      reg_trans <= HTRANSS;
    end
  end

  // Payload fields
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr  <= HADDRS;
      reg_write <= HWRITES;
      reg_size  <= HSIZES;
      reg_burst <= HBURSTS;
      reg_prot  <= HPROTS;
    end
  end

  // --------------------------------------------------------------------
  // Output select
  // --------------------------------------------------------------------

  always_comb
  begin
    if (pend)
    begin
      sel_ip    = 1'b1;        // Held beat always selected
      addr_ip   = reg_addr;
      write_ip  = reg_write;
      size_ip   = reg_size;
      prot_ip   = reg_prot;
      trans_mux = TRN_NONSEQ;  // Restarts at the output stage
      burst_mux = reg_burst;
      trans_src = reg_trans;
    end
    else
    begin
      sel_ip    = HSELS;       // Direct path, zero latency
      addr_ip   = HADDRS;
      write_ip  = HWRITES;
      size_ip   = HSIZES;
      prot_ip   = HPROTS;
      trans_mux = HTRANSS;
      burst_mux = HBURSTS;
      trans_src = HTRANSS;
    end
  end

endmodule : ahbic_hold_reg

`default_nettype wire

//--- ahbic_in/ahbic_hold_ctrl.sv
// Transfer acceptance, pending state, held_tran request and response return

`timescale 1ns/10ps
`default_nettype none

module ahbic_hold_ctrl
  import ahbic_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  input  wire          HSELS,
  input  wire htrans_t HTRANSS,
  input  wire          HREADYS,
  input  wire          active_ip,    // Output stage owns this port
  input  wire          readyout_ip,  // Output stage beat done
  input  wire hresp_t  resp_ip,
  output logic         load_reg,     // Accept into holding register
  output logic         hold_start,   // Accepted while output stage busy
  output logic         pend,         // Held transfer outstanding
  output logic         held_tran,
  output logic         HREADYOUTS,
  output hresp_t       HRESPS
);

  logic addr_valid;  // Selected NONSEQ or SEQ
  logic pend_nxt;
  logic data_valid;  // Data phase of a valid transfer

  // --------------------------------------------------------------------
  // Address phase acceptance
  // --------------------------------------------------------------------

  assign addr_valid = HSELS & HTRANSS[1];   // IDLE and BUSY ignored
  assign load_reg   = addr_valid & HREADYS; // Only on a finished previous beat
  assign hold_start = load_reg & ~active_ip;

  // Data phase follows every accepted beat
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_valid <= 1'b0;
    end
    else if (HREADYS)
    begin
      data_valid <= addr_valid;
    end
  end

  // --------------------------------------------------------------------
  // Pending transfer
  // --------------------------------------------------------------------

  // New hold wins over completion of the old one
  always_comb
  begin
    if (hold_start)
    begin
      pend_nxt = 1'b1;
    end
    else if (active_ip && readyout_ip)
    begin
      pend_nxt = 1'b0;  // Held beat done at output stage
    end
    else
    begin
      pend_nxt = pend;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      pend <= 1'b0;
    end
    else
    begin
      pend <= pend_nxt;
    end
  end

  // Arbiter request, direct beat or held beat
  assign held_tran = load_reg | pend;

  // --------------------------------------------------------------------
  // Response to the master
  // --------------------------------------------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;       // No data phase here
      HRESPS     = RSP_OKAY;
    end
    else if (pend)
    begin
      HREADYOUTS = 1'b0;       // Stall until held beat completes
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;    // Straight from output stage
    end
  end

endmodule : ahbic_hold_ctrl

`default_nettype wire

//--- common/ahbic_pkg.sv
// AHB encodings (HTRANS, HBURST, HSIZE, HRESP) and field widths for the input stage

`default_nettype none

package ahbic_pkg;

  // --------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------

  localparam int unsigned HPROT_W    = 4;  // HPROT field
  localparam int unsigned WRAP_OFS_W = 4;  // Beat offset, up to 16 beats

  // --------------------------------------------------------------------
  // Bus encodings
  // --------------------------------------------------------------------

  // Transfer type
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,  // No transfer
    TRN_BUSY   = 2'b01,  // Master inserting a wait inside a burst
    TRN_NONSEQ = 2'b10,  // First beat or single
    TRN_SEQ    = 2'b11   // Remaining beats
  } htrans_t;

  // Burst type
  typedef enum logic [2:0] {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001,  // Undefined length
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_t;

  // Transfer size, bits per beat
  typedef enum logic [2:0] {
    SZ_8    = 3'b000,
    SZ_16   = 3'b001,
    SZ_32   = 3'b010,
    SZ_64   = 3'b011,
    SZ_128  = 3'b100,  // Wider sizes not used for wrap checks
    SZ_256  = 3'b101,
    SZ_512  = 3'b110,
    SZ_1024 = 3'b111
  } hsize_t;

  // Response, AHB-Lite subset only
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01
  } hresp_t;

endpackage : ahbic_pkg

`default_nettype wire
